// ==== hw/motorPkg.sv ====
package motorPkg;

    // counter and field widths.
    localparam int CNT_W   = 25;
    localparam int SPLIT_W = 2;
    localparam int STEP_W  = 4;
    localparam int REV_W   = 16;

    // electrical cycle runs 0 to STEP_LAST, STEP_IDLE means not driving.
    localparam logic [STEP_W-1:0] STEP_LAST = 4'd11;
    localparam logic [STEP_W-1:0] STEP_IDLE = 4'd15;

    localparam logic [CNT_W-1:0] SPEED_MIN  = 25'd4;  // shortest sub-step.
    localparam logic [CNT_W-1:0] SPEED_STEP = 25'd16; // per inc/dec pulse.

    // gate-off cycles before a phase may drive the other side.
    localparam logic [1:0] DEAD_CYCLES = 2'd3;

    // register map.
    localparam logic [1:0] ADDR_SPEED  = 2'd0;
    localparam logic [1:0] ADDR_SPLIT  = 2'd1;
    localparam logic [1:0] ADDR_CTRL   = 2'd2; // run in bit 0.
    localparam logic [1:0] ADDR_STATUS = 2'd3; // revolution count, read only.

    typedef struct packed {
        logic               run;
        logic [SPLIT_W-1:0] splitMax;
        logic [CNT_W-1:0]   speedSet;
    } motorCfg_t;

    typedef struct packed {
        logic [STEP_W-1:0]  posA;
        logic [STEP_W-1:0]  posB;
        logic [STEP_W-1:0]  posC;
        logic [SPLIT_W-1:0] splitStep;
        logic               active;
        logic               stepFirst; // first cycle of a new step.
    } stepState_t;

    typedef struct packed {
        logic [2:0] hi; // bit 0 is phase A.
        logic [2:0] lo;
    } gateDrive_t;

endpackage

// ==== hw/motorRegs.sv ====
`timescale 1ns/1ps

module motorRegs (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         wrEn,
    input  logic [1:0]                   wrAddr,
    input  logic [31:0]                  wrData,
    input  logic [1:0]                   rdAddr,
    input  logic                         freqInc,
    input  logic                         freqDec,
    input  logic [motorPkg::REV_W-1:0]   revCount,
    output logic [31:0]                  rdData,
    output motorPkg::motorCfg_t          cfg
);

    logic [motorPkg::CNT_W-1:0]   speedReg;
    logic [motorPkg::CNT_W-1:0]   speedNext;
    logic [motorPkg::CNT_W-1:0]   wrSpeed;
    logic [motorPkg::SPLIT_W-1:0] splitReg;
    logic                         runReg;
    logic                         speedWr;

    assign wrSpeed = wrData[motorPkg::CNT_W-1:0];
    assign speedWr = wrEn && (wrAddr == motorPkg::ADDR_SPEED);

    // next speed value, a write wins over the pulses.
    always_comb begin
        speedNext = speedReg;
        if (speedWr) begin
            if (wrSpeed < motorPkg::SPEED_MIN) begin
                speedNext = motorPkg::SPEED_MIN;
            end else begin
                speedNext = wrSpeed;
            end
        end else if (freqInc && !freqDec) begin
            if (speedReg > ({motorPkg::CNT_W{1'b1}} - motorPkg::SPEED_STEP)) begin
                speedNext = {motorPkg::CNT_W{1'b1}}; // saturate at top.
            end else begin
                speedNext = speedReg + motorPkg::SPEED_STEP;
            end
        end else if (freqDec && !freqInc) begin
            if (speedReg < (motorPkg::SPEED_MIN + motorPkg::SPEED_STEP)) begin
                speedNext = motorPkg::SPEED_MIN;
            end else begin
                speedNext = speedReg - motorPkg::SPEED_STEP;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            speedReg <= motorPkg::SPEED_MIN;
            splitReg <= '0;
            runReg   <= 1'b0;
        end else begin
            speedReg <= speedNext;
            if (wrEn && wrAddr == motorPkg::ADDR_SPLIT) begin
                splitReg <= wrData[motorPkg::SPLIT_W-1:0];
            end
            if (wrEn && wrAddr == motorPkg::ADDR_CTRL) begin
                runReg <= wrData[0];
            end
        end
    end

    always_comb begin
        cfg.run      = runReg;
        cfg.splitMax = splitReg;
        cfg.speedSet = speedReg;
    end

    // readback is combinational.
    always_comb begin
        case (rdAddr)
            motorPkg::ADDR_SPEED:  rdData = 32'(speedReg);
            motorPkg::ADDR_SPLIT:  rdData = 32'(splitReg);
            motorPkg::ADDR_CTRL:   rdData = 32'(runReg);
            motorPkg::ADDR_STATUS: rdData = 32'(revCount);
            default:               rdData = '0;
        endcase
    end

endmodule

// ==== hw/stepGenerator.sv ====
`timescale 1ns/1ps

module stepGenerator (
    input  logic                        clk,
    input  logic                        rstN,
    input  motorPkg::motorCfg_t         cfg,
    output motorPkg::stepState_t        step,
    output logic [motorPkg::REV_W-1:0]  revCount
);

    logic                           runDly;
    logic                           runRise;
    logic [motorPkg::CNT_W-1:0]     cnt;
    logic [motorPkg::CNT_W-1:0]     speedLat;
    logic [motorPkg::SPLIT_W-1:0]   splitLat;
    logic [motorPkg::SPLIT_W-1:0]   splitStep;
    logic [motorPkg::STEP_W-1:0]    posA;
    logic [motorPkg::STEP_W-1:0]    posB;
    logic [motorPkg::STEP_W-1:0]    posC;
    logic                           stepFirst;
    logic                           cntLast;
    logic                           stepEnd;

    assign runRise = cfg.run && !runDly;
    assign cntLast = (cnt == 1);
    // last cycle of the last sub-step of a step.
    assign stepEnd = cfg.run && cntLast && (splitStep == '0);

    // speed and split hold for the whole run.
    always_ff @(posedge clk) begin
        if (runRise) begin
            speedLat <= cfg.speedSet;
            splitLat <= cfg.splitMax;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runDly    <= 1'b0;
            cnt       <= '0;
            splitStep <= '0;
            posA      <= motorPkg::STEP_IDLE;
            stepFirst <= 1'b0;
            revCount  <= '0;
        end else begin
            runDly    <= cfg.run;
            stepFirst <= runRise || stepEnd;
            if (runRise) begin
                cnt       <= cfg.speedSet;
                splitStep <= cfg.splitMax;
                posA      <= '0;
                revCount  <= '0;
            end else if (!cfg.run) begin
                posA <= motorPkg::STEP_IDLE; // counter holds.
            end else if (cntLast) begin
                cnt <= speedLat;
                if (splitStep == '0) begin
                    splitStep <= splitLat;
                    if (posA == motorPkg::STEP_LAST) begin
                        posA     <= '0;
                        revCount <= revCount + 1; // one full electrical cycle.
                    end else begin
                        posA <= posA + 1;
                    end
                end else begin
                    splitStep <= splitStep - 1;
                end
            end else begin
                cnt <= cnt - 1;
            end
        end
    end

    // B lags A by 120 degrees, C leads by 120 degrees.
    always_comb begin
        case (posA)
            4'd0:    {posB, posC} = {4'd8,  4'd4};
            4'd1:    {posB, posC} = {4'd9,  4'd5};
            4'd2:    {posB, posC} = {4'd10, 4'd6};
            4'd3:    {posB, posC} = {4'd11, 4'd7};
            4'd4:    {posB, posC} = {4'd0,  4'd8};
            4'd5:    {posB, posC} = {4'd1,  4'd9};
            4'd6:    {posB, posC} = {4'd2,  4'd10};
            4'd7:    {posB, posC} = {4'd3,  4'd11};
            4'd8:    {posB, posC} = {4'd4,  4'd0};
            4'd9:    {posB, posC} = {4'd5,  4'd1};
            4'd10:   {posB, posC} = {4'd6,  4'd2};
            4'd11:   {posB, posC} = {4'd7,  4'd3};
            default: {posB, posC} = {motorPkg::STEP_IDLE, motorPkg::STEP_IDLE};
        endcase
    end

    always_comb begin
        step.posA      = posA;
        step.posB      = posB;
        step.posC      = posC;
        step.splitStep = splitStep;
        step.active    = (posA <= motorPkg::STEP_LAST);
        step.stepFirst = stepFirst;
    end

endmodule

// ==== hw/phaseDriver.sv ====
`timescale 1ns/1ps

module phaseDriver (
    input  logic                    clk,
    input  logic                    rstN,
    input  motorPkg::stepState_t    step,
    output motorPkg::gateDrive_t    gates
);

    logic [motorPkg::STEP_W-1:0]             pos [3];
    logic [2:0]                              tgtHi;
    logic [2:0]                              tgtLo;
    logic [2:0]                              lastHi;  // side that was driven last.
    logic [$bits(motorPkg::DEAD_CYCLES)-1:0] deadCnt [3];

    assign pos[0] = step.posA;
    assign pos[1] = step.posB;
    assign pos[2] = step.posC;

    // target per phase: 0..3 high, 6..9 low, otherwise floating.
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tgtHi[i] = step.active && (pos[i] <= 4'd3);
            tgtLo[i] = step.active && (pos[i] >= 4'd6) && (pos[i] <= 4'd9);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gates  <= '0;
            lastHi <= '0;
            for (int i = 0; i < 3; i++) begin
                deadCnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (!tgtHi[i] && !tgtLo[i]) begin
                    gates.hi[i] <= 1'b0;
                    gates.lo[i] <= 1'b0;
                    // dead time starts when a gate drops.
                    if (gates.hi[i] || gates.lo[i]) begin
                        deadCnt[i] <= motorPkg::DEAD_CYCLES;
                    end else if (deadCnt[i] != '0) begin
                        deadCnt[i] <= deadCnt[i] - 1;
                    end
                end else if ((tgtHi[i] && gates.lo[i]) || (tgtLo[i] && gates.hi[i])) begin
                    gates.hi[i] <= 1'b0; // direct reversal.
                    gates.lo[i] <= 1'b0;
                    deadCnt[i]  <= motorPkg::DEAD_CYCLES;
                end else if (deadCnt[i] != '0 && tgtHi[i] != lastHi[i]) begin
                    deadCnt[i] <= deadCnt[i] - 1; // other side still settling.
                end else begin
                    gates.hi[i] <= tgtHi[i];
                    gates.lo[i] <= tgtLo[i];
                    lastHi[i]   <= tgtHi[i];
                    deadCnt[i]  <= '0;
                end
            end
        end
    end

endmodule

// ==== hw/motorCore.sv ====
`timescale 1ns/1ps

module motorCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    wrEn,
    input  logic [1:0]              wrAddr,
    input  logic [31:0]             wrData,
    input  logic [1:0]              rdAddr,
    input  logic                    freqInc,
    input  logic                    freqDec,
    output logic [31:0]             rdData,
    output motorPkg::gateDrive_t    gates
);

    motorPkg::motorCfg_t           cfg;
    motorPkg::stepState_t          step;
    logic [motorPkg::REV_W-1:0]    revCount;

    // configuration, speed adjust and readback.
    motorRegs regs0 (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdAddr   (rdAddr),
        .freqInc  (freqInc),
        .freqDec  (freqDec),
        .revCount (revCount),
        .rdData   (rdData),
        .cfg      (cfg)
    );

    stepGenerator stepGen0 (
        .clk      (clk),
        .rstN     (rstN),
        .cfg      (cfg),
        .step     (step),
        .revCount (revCount)
    );

    // gate levels with dead time.
    phaseDriver driver0 (
        .clk   (clk),
        .rstN  (rstN),
        .step  (step),
        .gates (gates)
    );

endmodule

// ==== sim/motorCore_checker.sv ====
`timescale 1ns/1ps

module motorCoreChecker (
    input logic                 clk,
    input logic                 rstN,
    input motorPkg::stepState_t step,
    input motorPkg::gateDrive_t gates
);

    logic [3:0] hiIdle [3]; // saturating count of samples since the hi gate was last on.
    logic [3:0] loIdle [3];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 3; i++) begin
                hiIdle[i] <= 4'hF;
                loIdle[i] <= 4'hF;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (gates.hi[i]) begin
                    hiIdle[i] <= 4'd0;
                end else if (hiIdle[i] != 4'hF) begin
                    hiIdle[i] <= hiIdle[i] + 4'd1;
                end
                if (gates.lo[i]) begin
                    loIdle[i] <= 4'd0;
                end else if (loIdle[i] != 4'hF) begin
                    loIdle[i] <= loIdle[i] + 4'd1;
                end
            end
        end
    end

    noShootThrough: assert property (@(posedge clk) disable iff (!rstN)
        (gates.hi & gates.lo) == 3'b000)
        else $error("hi and lo on together, hi=%b lo=%b", gates.hi, gates.lo);

    // the opposite gate may only rise after the full dead time.
    for (genvar i = 0; i < 3; i++) begin : gPhase
        loAfterHi: assert property (@(posedge clk) disable iff (!rstN)
            $rose(gates.lo[i]) |-> hiIdle[i] > 4'(motorPkg::DEAD_CYCLES))
            else $error("phase %0d lo gate rose inside the dead time", i);
        hiAfterLo: assert property (@(posedge clk) disable iff (!rstN)
            $rose(gates.hi[i]) |-> loIdle[i] > 4'(motorPkg::DEAD_CYCLES))
            else $error("phase %0d hi gate rose inside the dead time", i);
    end

    // a new step starts exactly when posA moves to a driving position.
    stepFirstOnMove: assert property (@(posedge clk) disable iff (!rstN)
        step.stepFirst == (step.active && (step.posA != $past(step.posA))))
        else $error("stepFirst is %b with posA at %0d", step.stepFirst, step.posA);

    // within a step the sub-step count only counts down.
    splitCountDown: assert property (@(posedge clk) disable iff (!rstN)
        (step.active && !step.stepFirst && (step.splitStep != $past(step.splitStep)))
        |-> step.splitStep == $past(step.splitStep) - 2'd1)
        else $error("sub-step count jumped to %0d", step.splitStep);

    offInReset: assert property (@(posedge clk) !rstN |-> gates == '0)
        else $error("gates driven during reset, hi=%b lo=%b", gates.hi, gates.lo);

endmodule

// ==== sim/motorTb.sv ====
`timescale 1ns/1ps

module motorTb;

    logic                 clk;
    logic                 rstN;
    logic                 wrEn;
    logic [1:0]           wrAddr;
    logic [31:0]          wrData;
    logic [1:0]           rdAddr;
    logic                 freqInc;
    logic                 freqDec;
    logic [31:0]          rdData;
    motorPkg::gateDrive_t gates;
    int                   cycleCnt = 0;

    motorCore dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rdAddr  (rdAddr),
        .freqInc (freqInc),
        .freqDec (freqDec),
        .rdData  (rdData),
        .gates   (gates)
    );

    bind motorCore motorCoreChecker checker0 (
        .clk   (clk),
        .rstN  (rstN),
        .step  (step),
        .gates (gates)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    // worst case is the slowest random speed and split in the three run tests.
    initial begin
        int maxPeriod;
        int worstCycles;
        maxPeriod   = (int'(motorPkg::SPEED_MIN) + 7) * (2 ** motorPkg::SPLIT_W);
        worstCycles = 200 + 3 * (14 * maxPeriod + 30) + 24 * int'(motorPkg::SPEED_MIN);
        #(2 * worstCycles * 10);
        stopOnError("Watchdog timeout: the tests did not finish in time");
    end

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error: %s expected 0x%08h actual 0x%08h",
                                  name, expected, actual));
        end
    endtask

    task automatic checkGates(input string name, input motorPkg::gateDrive_t expected,
                              input motorPkg::gateDrive_t actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error: %s expected hi=%b lo=%b actual hi=%b lo=%b",
                                  name, expected.hi, expected.lo, actual.hi, actual.lo));
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stopOnError($sformatf("Error: %s expected %0d cycles actual %0d cycles",
                                  name, expected, actual));
        end
    endtask

    task automatic checkGapAtLeast(input string name, input int minimum, input int actual);
        if (actual < minimum) begin
            stopOnError($sformatf("Error: %s expected at least %0d cycles actual %0d cycles",
                                  name, minimum, actual));
        end
    endtask

    // {hi, lo} target of one phase at position pos.
    function automatic logic [1:0] phaseTarget(input int pos);
        if (pos >= 0 && pos <= 3) return 2'b10;
        if (pos >= 6 && pos <= 9) return 2'b01;
        return 2'b00;
    endfunction

    function automatic motorPkg::gateDrive_t expectGates(input int posA);
        motorPkg::gateDrive_t g;
        int                   offset [3];
        logic [1:0]           t;
        offset[0] = 0;
        offset[1] = 8; // B lags A by 120 degrees.
        offset[2] = 4;
        g = '0;
        for (int ph = 0; ph < 3; ph++) begin
            t        = phaseTarget((posA + offset[ph]) % 12);
            g.hi[ph] = t[1];
            g.lo[ph] = t[0];
        end
        return g;
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
        waitCycles(1);
        wrEn   = 1'b0;
    endtask

    task automatic expectReg(input string name, input logic [1:0] addr,
                             input logic [31:0] expected);
        rdAddr = addr;
        #1;
        checkWord(name, expected, rdData);
        waitCycles(1);
    endtask

    task automatic pulseSpeed(input logic inc, input logic dec);
        freqInc = inc;
        freqDec = dec;
        waitCycles(1);
        freqInc = 1'b0;
        freqDec = 1'b0;
    endtask

    // returns on the first cycle of step 0.
    task automatic startRun(input int speed, input int split);
        writeReg(motorPkg::ADDR_SPEED, 32'(speed));
        writeReg(motorPkg::ADDR_SPLIT, 32'(split));
        writeReg(motorPkg::ADDR_CTRL, 32'd1);
        waitCycles(1);
    endtask

    task automatic stopRun(input string name);
        writeReg(motorPkg::ADDR_CTRL, 32'd0);
        waitCycles(2);
        checkGates(name, '0, gates);
        waitCycles(4); // let the dead-time counters drain.
    endtask

    task automatic waitPhaseA(input logic [1:0] target);
        while ({gates.hi[0], gates.lo[0]} != target) begin
            waitCycles(1);
        end
    endtask

    task automatic testReset();
        checkGates("reset gates", '0, gates);
        expectReg("reset speed", motorPkg::ADDR_SPEED, 32'(motorPkg::SPEED_MIN));
        expectReg("reset split", motorPkg::ADDR_SPLIT, 32'd0);
        expectReg("reset ctrl", motorPkg::ADDR_CTRL, 32'd0);
        expectReg("reset status", motorPkg::ADDR_STATUS, 32'd0);
    endtask

    task automatic testRegRules();
        logic [31:0] allOnes;
        logic [31:0] minSpeed;
        allOnes  = (32'd1 << motorPkg::CNT_W) - 32'd1;
        minSpeed = 32'(motorPkg::SPEED_MIN);
        writeReg(motorPkg::ADDR_SPEED, 32'd100);
        expectReg("speed write", motorPkg::ADDR_SPEED, 32'd100);
        writeReg(motorPkg::ADDR_SPLIT, 32'd3);
        expectReg("split write", motorPkg::ADDR_SPLIT, 32'd3);
        writeReg(motorPkg::ADDR_SPEED, 32'd2);
        expectReg("speed clamp", motorPkg::ADDR_SPEED, minSpeed);
        writeReg(motorPkg::ADDR_STATUS, 32'd7);
        expectReg("status read only", motorPkg::ADDR_STATUS, 32'd0);
        writeReg(motorPkg::ADDR_SPEED, 32'd40);
        pulseSpeed(1'b1, 1'b0);
        expectReg("speed inc", motorPkg::ADDR_SPEED, 32'd40 + 32'(motorPkg::SPEED_STEP));
        pulseSpeed(1'b0, 1'b1);
        expectReg("speed dec", motorPkg::ADDR_SPEED, 32'd40);
        pulseSpeed(1'b1, 1'b1);
        expectReg("speed inc and dec", motorPkg::ADDR_SPEED, 32'd40);
        freqInc = 1'b1; // write must win over the pulse.
        writeReg(motorPkg::ADDR_SPEED, 32'd200);
        freqInc = 1'b0;
        expectReg("write over inc", motorPkg::ADDR_SPEED, 32'd200);
        writeReg(motorPkg::ADDR_SPEED, minSpeed + 32'd5);
        pulseSpeed(1'b0, 1'b1);
        expectReg("dec saturate", motorPkg::ADDR_SPEED, minSpeed);
        pulseSpeed(1'b0, 1'b1);
        expectReg("dec at floor", motorPkg::ADDR_SPEED, minSpeed);
        writeReg(motorPkg::ADDR_SPEED, allOnes - 32'd3);
        pulseSpeed(1'b1, 1'b0);
        expectReg("inc saturate", motorPkg::ADDR_SPEED, allOnes);
        pulseSpeed(1'b1, 1'b0);
        expectReg("inc at ceiling", motorPkg::ADDR_SPEED, allOnes);
    endtask

    task automatic testCommutation();
        int speed;
        int split;
        int period;
        speed  = int'(motorPkg::SPEED_MIN) + int'($urandom % 8);
        split  = int'($urandom % 4);
        period = speed * (split + 1);
        startRun(speed, split);
        waitCycles(period / 2); // sample at mid-step.
        for (int s = 0; s < 13; s++) begin
            checkGates($sformatf("commutation step %0d", s), expectGates(s % 12), gates);
            waitCycles(period);
        end
        stopRun("commutation stop");
    endtask

    task automatic testStepPeriod();
        int         speed;
        int         split;
        int         period;
        int         startCycle;
        int         expSteps [$];
        int         changeAt [$];
        logic [1:0] prevDrive;
        logic [1:0] prevTarget;
        speed  = int'(motorPkg::SPEED_MIN) + int'($urandom % 8);
        split  = int'($urandom % 4);
        period = speed * (split + 1);
        prevTarget = 2'b00;
        for (int s = 0; s <= 12; s++) begin
            if (phaseTarget(s % 12) != prevTarget) begin
                expSteps.push_back(s);
            end
            prevTarget = phaseTarget(s % 12);
        end
        startRun(speed, split);
        startCycle = cycleCnt;
        prevDrive  = 2'b00;
        while (changeAt.size() < expSteps.size()) begin
            waitCycles(1);
            if ({gates.hi[0], gates.lo[0]} != prevDrive) begin
                changeAt.push_back(cycleCnt);
                prevDrive = {gates.hi[0], gates.lo[0]};
            end
        end
        checkCycles("first gate latency", 1, changeAt[0] - startCycle); // driver stage.
        for (int i = 1; i < changeAt.size(); i++) begin
            checkCycles($sformatf("step period change %0d", i),
                        (expSteps[i] - expSteps[i-1]) * period, changeAt[i] - changeAt[i-1]);
        end
        stopRun("step period stop");
    endtask

    task automatic testDeadTime();
        int speed;
        int split;
        int fallAt;
        speed = int'(motorPkg::SPEED_MIN) + int'($urandom % 8);
        split = int'($urandom % 4);
        startRun(speed, split);
        waitPhaseA(2'b10);
        waitPhaseA(2'b00);
        fallAt = cycleCnt;
        waitPhaseA(2'b01);
        checkGapAtLeast("dead time hi to lo", int'(motorPkg::DEAD_CYCLES) + 1,
                        cycleCnt - fallAt);
        waitPhaseA(2'b00);
        fallAt = cycleCnt;
        waitPhaseA(2'b10);
        checkGapAtLeast("dead time lo to hi", int'(motorPkg::DEAD_CYCLES) + 1,
                        cycleCnt - fallAt);
        stopRun("dead time stop");
    endtask

    task automatic testRevolutions();
        int speed;
        int revs;
        speed = int'(motorPkg::SPEED_MIN);
        revs  = 2;
        startRun(speed, 0);
        waitCycles(12 * speed * revs + speed / 2);
        expectReg("revolution count", motorPkg::ADDR_STATUS, 32'(revs));
        stopRun("revolution stop");
        expectReg("revolution count held", motorPkg::ADDR_STATUS, 32'(revs));
    endtask

    initial begin
        void'($urandom(55));
        rstN    = 1'b0;
        wrEn    = 1'b0;
        wrAddr  = '0;
        wrData  = '0;
        rdAddr  = '0;
        freqInc = 1'b0;
        freqDec = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        waitCycles(1);
        testReset();
        testRegRules();
        testCommutation();
        testStepPeriod();
        testDeadTime();
        testRevolutions();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== src.f ====
hw/motorPkg.sv
hw/motorRegs.sv
hw/stepGenerator.sv
hw/phaseDriver.sv
hw/motorCore.sv
sim/motorCore_checker.sv
sim/motorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the motor core testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module motorTb -f src.f -o motorSim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/motorSim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
